// File: hw/rename_consts.svh
// ----------------------------------------------------------
// Rename subsystem constants
// Widths, register counts and the widths derived from them
// ----------------------------------------------------------

`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Slots per cycle
`define RENAME_WIDTH 2
`define COMMIT_WIDTH 2

// Register file sizes
`define LREG_NUM 16
`define PREG_NUM 32
`define LREG_BITS 4
`define PREG_BITS 5

`define FREE_LIST_SIZE (`PREG_NUM - `LREG_NUM)
`define RESTORE_CYCLES (`LREG_NUM / `RENAME_WIDTH)

`endif

// File: hw/RegTypesPkg.sv
// ----------------------------------------------------------
// Register number types
// Logical and physical register numbers, free-list pointers
// and occupancy counts
// ----------------------------------------------------------

`include "rename_consts.svh"

package RegTypesPkg;

    // Architectural register as seen by the front end
    typedef logic [`LREG_BITS-1:0] LRegNum;

    // Entry of the physical register file
    typedef logic [`PREG_BITS-1:0] PRegNum;

    // Free-list index plus one wrap bit
    typedef logic [$clog2(`FREE_LIST_SIZE):0] FreeListPtr;

    // Holds 0 up to FREE_LIST_SIZE inclusive
    typedef logic [$clog2(`FREE_LIST_SIZE):0] FreeListCount;

endpackage

// File: hw/RenamePortPkg.sv
// ----------------------------------------------------------
// Rename port types
// Rename, commit and map-write structs and the recovery state
// ----------------------------------------------------------

package RenamePortPkg;

    import RegTypesPkg::*;

    typedef struct packed {
        logic   valid;
        logic   writeReg;
        LRegNum logDst;
        LRegNum logSrc1;
        LRegNum logSrc2;
    } RenameReq;

    typedef struct packed {
        PRegNum phyDst;
        PRegNum prevPhyDst;
        PRegNum phySrc1;
        PRegNum phySrc2;
    } RenameResp;

    // prevPhyDst goes back to the free list
    typedef struct packed {
        logic   valid;
        logic   writeReg;
        LRegNum logDst;
        PRegNum phyDst;
        PRegNum prevPhyDst;
    } CommitReq;

    typedef enum logic {
        Idle,
        Restore
    } RecoveryState;

    typedef struct packed {
        logic   we;
        LRegNum logReg;
        PRegNum phyReg;
    } MapWrite;

endpackage

// File: hw/FreeList.sv
// ----------------------------------------------------------
// Free list of physical registers
// Circular buffer with a speculative and a committed read
// pointer, restored in one step on a flush
// ----------------------------------------------------------

`include "rename_consts.svh"

module FreeList
    import RegTypesPkg::*;
    import RenamePortPkg::*;
(
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [`RENAME_WIDTH-1:0] pop,
    output PRegNum                   popNum [`RENAME_WIDTH],
    input  CommitReq                 push [`COMMIT_WIDTH],
    input  logic                     restorePtr,
    output FreeListCount             count
);

    localparam int idxBits = $clog2(`FREE_LIST_SIZE);

    PRegNum       entries [`FREE_LIST_SIZE];
    FreeListPtr   wrPtr;
    FreeListPtr   specRdPtr;
    FreeListPtr   comRdPtr;
    FreeListPtr   comRdPtrNext;
    FreeListPtr   pushAddr [`COMMIT_WIDTH];
    FreeListCount popCnt;
    FreeListCount pushCnt;
    logic [`COMMIT_WIDTH-1:0] pushEn;

    assign count = FreeListCount'(wrPtr - specRdPtr);

    // Pops take consecutive entries from the speculative head
    always_comb begin
        FreeListPtr rdPtr;
        rdPtr  = specRdPtr;
        popCnt = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            popNum[i] = entries[rdPtr[idxBits-1:0]];
            if (pop[i]) begin
                rdPtr  = rdPtr + FreeListPtr'(1);
                popCnt = popCnt + FreeListCount'(1);
            end
        end
    end

    // Each writing commit returns one register and retires one allocation
    always_comb begin
        FreeListPtr wp;
        wp      = wrPtr;
        pushCnt = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            pushEn[i]   = push[i].valid && push[i].writeReg;
            pushAddr[i] = wp;
            if (pushEn[i]) begin
                wp      = wp + FreeListPtr'(1);
                pushCnt = pushCnt + FreeListCount'(1);
            end
        end
        comRdPtrNext = comRdPtr + FreeListPtr'(pushCnt);
    end

    // Starts full with the registers above the identity mapping
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `FREE_LIST_SIZE; i++) begin
                entries[i] <= PRegNum'(`LREG_NUM + i);
            end
        end else begin
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (pushEn[i]) begin
                    entries[pushAddr[i][idxBits-1:0]] <= push[i].prevPhyDst;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr     <= FreeListPtr'(`FREE_LIST_SIZE);
            specRdPtr <= '0;
            comRdPtr  <= '0;
        end else begin
            wrPtr    <= wrPtr + FreeListPtr'(pushCnt);
            comRdPtr <= comRdPtrNext;
            // Flush drops every squashed allocation at once
            if (restorePtr) begin
                specRdPtr <= comRdPtrNext;
            end else begin
                specRdPtr <= specRdPtr + FreeListPtr'(popCnt);
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) popCnt <= count)
        else $error("free list popped below empty");

    assert property (@(posedge clk) disable iff (!rstN)
        int'(count) + int'(pushCnt) <= `FREE_LIST_SIZE)
        else $error("free list pushed above full");

endmodule

// File: hw/RenameMapTable.sv
// ----------------------------------------------------------
// Speculative register map table
// Source and previous-destination lookup with in-group
// bypass, plus two write ports for renames or restore
// ----------------------------------------------------------

`include "rename_consts.svh"

module RenameMapTable
    import RegTypesPkg::*;
    import RenamePortPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  RenameReq  req [`RENAME_WIDTH],
    input  PRegNum    newDst [`RENAME_WIDTH],
    output RenameResp resp [`RENAME_WIDTH],
    input  MapWrite   wr [`RENAME_WIDTH]
);

    PRegNum map [`LREG_NUM];

    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            resp[i].phyDst     = newDst[i];
            resp[i].prevPhyDst = map[req[i].logDst];
            resp[i].phySrc1    = map[req[i].logSrc1];
            resp[i].phySrc2    = map[req[i].logSrc2];
            // Later slots see destinations renamed earlier in the same group
            for (int j = 0; j < i; j++) begin
                if (req[j].valid && req[j].writeReg) begin
                    if (req[j].logDst == req[i].logDst) begin
                        resp[i].prevPhyDst = newDst[j];
                    end
                    if (req[j].logDst == req[i].logSrc1) begin
                        resp[i].phySrc1 = newDst[j];
                    end
                    if (req[j].logDst == req[i].logSrc2) begin
                        resp[i].phySrc2 = newDst[j];
                    end
                end
            end
        end
    end

    // Identity after reset, higher port wins a collision
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `LREG_NUM; i++) begin
                map[i] <= PRegNum'(i);
            end
        end else begin
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (wr[i].we) begin
                    map[wr[i].logReg] <= wr[i].phyReg;
                end
            end
        end
    end

endmodule

// File: hw/RetireMapTable.sv
// ----------------------------------------------------------
// Retirement register map table
// Committed mappings, read pairwise while the speculative
// table is being restored
// ----------------------------------------------------------

`include "rename_consts.svh"

module RetireMapTable
    import RegTypesPkg::*;
    import RenamePortPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  CommitReq commit [`COMMIT_WIDTH],
    input  LRegNum   readIdx,
    output PRegNum   readPhy [`RENAME_WIDTH]
);

    PRegNum map [`LREG_NUM];

    // Consecutive entries starting at readIdx
    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            readPhy[i] = map[LRegNum'(readIdx + LRegNum'(i))];
        end
    end

    // Younger commit slot wins on the same register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `LREG_NUM; i++) begin
                map[i] <= PRegNum'(i);
            end
        end else begin
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (commit[i].valid && commit[i].writeReg) begin
                    map[commit[i].logDst] <= commit[i].phyDst;
                end
            end
        end
    end

endmodule

// File: hw/RenameLogic.sv
// ----------------------------------------------------------
// Rename control
// Drives free-list pops and map writes, walks the restore
// copy after a flush and produces the ready flag
// ----------------------------------------------------------

`include "rename_consts.svh"

module RenameLogic
    import RegTypesPkg::*;
    import RenamePortPkg::*;
(
    input  logic                     clk,
    input  logic                     rstN,
    input  RenameReq                 req [`RENAME_WIDTH],
    input  logic                     flush,
    input  FreeListCount             freeCount,
    input  PRegNum                   popNum [`RENAME_WIDTH],
    output logic [`RENAME_WIDTH-1:0] pop,
    output logic                     restorePtr,
    output PRegNum                   newDst [`RENAME_WIDTH],
    output MapWrite                  mapWr [`RENAME_WIDTH],
    output LRegNum                   retireIdx,
    input  PRegNum                   retirePhy [`RENAME_WIDTH],
    output logic                     ready
);

    // First index of the final restore step
    localparam LRegNum lastIdx = LRegNum'((`RESTORE_CYCLES - 1) * `RENAME_WIDTH);

    RecoveryState state;
    LRegNum       restoreIdx;
    logic         anyValid;

    // Front end stalls during restore or when a full group cannot allocate
    assign ready      = (state == Idle) && (freeCount >= FreeListCount'(`RENAME_WIDTH));
    assign restorePtr = flush;
    assign retireIdx  = restoreIdx;

    always_comb begin
        anyValid = 1'b0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            anyValid  = anyValid || req[i].valid;
            // Slot 1 allocates only behind a valid slot 0
            pop[i]    = ready && req[i].valid && req[i].writeReg && (i == 0 || req[0].valid);
            newDst[i] = popNum[i];
            if (state == Restore) begin
                mapWr[i].we     = 1'b1;
                mapWr[i].logReg = restoreIdx + LRegNum'(i);
                mapWr[i].phyReg = retirePhy[i];
            end else begin
                mapWr[i].we     = pop[i];
                mapWr[i].logReg = req[i].logDst;
                mapWr[i].phyReg = popNum[i];
            end
        end
    end

    // A new flush restarts the walk from entry 0
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= Idle;
            restoreIdx <= '0;
        end else if (flush) begin
            state      <= Restore;
            restoreIdx <= '0;
        end else if (state == Restore) begin
            restoreIdx <= restoreIdx + LRegNum'(`RENAME_WIDTH);
            if (restoreIdx == lastIdx) begin
                state <= Idle;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) !ready |-> !anyValid)
        else $error("rename request while not ready");

    assert property (@(posedge clk) disable iff (!rstN) flush |-> !anyValid)
        else $error("rename request in the flush cycle");

endmodule

// File: hw/RenameUnit.sv
// ----------------------------------------------------------
// Register rename unit
// Two-wide renaming with a free list, a speculative map and
// a retirement map used for flush recovery
// ----------------------------------------------------------

`include "rename_consts.svh"

module RenameUnit
    import RegTypesPkg::*;
    import RenamePortPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  RenameReq  renameReq [`RENAME_WIDTH],
    output RenameResp renameResp [`RENAME_WIDTH],
    output logic      ready,
    input  CommitReq  commitReq [`COMMIT_WIDTH],
    input  logic      flush
);

    logic [`RENAME_WIDTH-1:0] pop;
    logic                     restorePtr;
    PRegNum                   popNum [`RENAME_WIDTH];
    PRegNum                   newDst [`RENAME_WIDTH];
    PRegNum                   retirePhy [`RENAME_WIDTH];
    FreeListCount             freeCount;
    MapWrite                  mapWr [`RENAME_WIDTH];
    LRegNum                   retireIdx;

    RenameLogic logic_i (
        .clk        (clk),
        .rstN       (rstN),
        .req        (renameReq),
        .flush      (flush),
        .freeCount  (freeCount),
        .popNum     (popNum),
        .pop        (pop),
        .restorePtr (restorePtr),
        .newDst     (newDst),
        .mapWr      (mapWr),
        .retireIdx  (retireIdx),
        .retirePhy  (retirePhy),
        .ready      (ready)
    );

    // Commits return prevPhyDst and advance the committed pointer
    FreeList freeList_i (
        .clk        (clk),
        .rstN       (rstN),
        .pop        (pop),
        .popNum     (popNum),
        .push       (commitReq),
        .restorePtr (restorePtr),
        .count      (freeCount)
    );

    RenameMapTable specMap_i (
        .clk    (clk),
        .rstN   (rstN),
        .req    (renameReq),
        .newDst (newDst),
        .resp   (renameResp),
        .wr     (mapWr)
    );

    RetireMapTable retireMap_i (
        .clk     (clk),
        .rstN    (rstN),
        .commit  (commitReq),
        .readIdx (retireIdx),
        .readPhy (retirePhy)
    );

endmodule

// File: tests/RenameUnitTb.sv
// ----------------------------------------------------------
// Testbench for the register rename unit
// Reference model of both maps and the free list, checked
// against the DUT by concurrent assertions
// ----------------------------------------------------------

`include "rename_consts.svh"

module RenameUnitTb
    import RegTypesPkg::*;
    import RenamePortPkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod = 100;
    // Cycle budget per test, reset first
    localparam int totalLen = 16 + 10 + 20 + 30 + 30 + 40;

    logic      clk;
    logic      rstN;
    logic      flush;
    logic      ready;
    RenameReq  renameReq [`RENAME_WIDTH];
    RenameResp renameResp [`RENAME_WIDTH];
    CommitReq  commitReq [`COMMIT_WIDTH];

    // Reference model state
    PRegNum    specMap [`LREG_NUM];
    PRegNum    comMap [`LREG_NUM];
    PRegNum    fl [$];
    CommitReq  inflight [$];
    int        specRd;
    int        comRd;
    int        restoreLeft;
    logic      expReady;
    RenameResp expResp [`RENAME_WIDTH];

    int        seed = 32'haa09;
    int        failCount = 0;
    int        failsAtStart = 0;
    int        passTests = 0;
    int        failTests = 0;

    RenameUnit dut_i (
        .clk        (clk),
        .rstN       (rstN),
        .renameReq  (renameReq),
        .renameResp (renameResp),
        .ready      (ready),
        .commitReq  (commitReq),
        .flush      (flush)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(totalLen * 2 * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", totalLen * 2);
        $display("TEST FAILED");
        $finish;
    end

    // Expected responses with slot 0 bypassed into slot 1
    always_comb begin
        logic byp;
        expReady = (restoreLeft == 0) && (fl.size() - specRd >= `RENAME_WIDTH);
        byp = renameReq[0].valid && renameReq[0].writeReg;
        expResp[0].phyDst     = fl[specRd];
        expResp[0].prevPhyDst = specMap[renameReq[0].logDst];
        expResp[0].phySrc1    = specMap[renameReq[0].logSrc1];
        expResp[0].phySrc2    = specMap[renameReq[0].logSrc2];
        expResp[1].phyDst     = fl[specRd + (byp ? 1 : 0)];
        expResp[1].prevPhyDst = (byp && renameReq[0].logDst == renameReq[1].logDst) ?
                                expResp[0].phyDst : specMap[renameReq[1].logDst];
        expResp[1].phySrc1    = (byp && renameReq[0].logDst == renameReq[1].logSrc1) ?
                                expResp[0].phyDst : specMap[renameReq[1].logSrc1];
        expResp[1].phySrc2    = (byp && renameReq[0].logDst == renameReq[1].logSrc2) ?
                                expResp[0].phyDst : specMap[renameReq[1].logSrc2];
    end

    always @(posedge clk or negedge rstN) begin
        CommitReq rec;
        logic     accept;
        if (!rstN) begin
            fl.delete();
            inflight.delete();
            for (int i = 0; i < `LREG_NUM; i++) begin
                specMap[i] = PRegNum'(i);
                comMap[i]  = PRegNum'(i);
            end
            for (int i = 0; i < `FREE_LIST_SIZE; i++) begin
                fl.push_back(PRegNum'(`LREG_NUM + i));
            end
            specRd      = 0;
            comRd       = 0;
            restoreLeft = 0;
        end else begin
            accept = expReady;
            // Accepted renames take free entries in slot order
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (accept && renameReq[i].valid && renameReq[i].writeReg &&
                    renameReq[0].valid) begin
                    rec.valid      = 1'b1;
                    rec.writeReg   = 1'b1;
                    rec.logDst     = renameReq[i].logDst;
                    rec.phyDst     = fl[specRd];
                    rec.prevPhyDst = specMap[rec.logDst];
                    specMap[rec.logDst] = rec.phyDst;
                    specRd++;
                    inflight.push_back(rec);
                end
            end
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (commitReq[i].valid && commitReq[i].writeReg) begin
                    fl.push_back(commitReq[i].prevPhyDst);
                    comMap[commitReq[i].logDst] = commitReq[i].phyDst;
                    comRd++;
                end
            end
            if (flush) begin
                specRd      = comRd;
                specMap     = comMap;
                restoreLeft = `RESTORE_CYCLES;
                inflight.delete();
            end else if (restoreLeft > 0) begin
                restoreLeft--;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) ready == expReady)
        else begin
            failCount++;
            $display("CHECK FAILED at %0d ns: ready is %b, expected %b",
                     $time, $sampled(ready), $sampled(expReady));
        end

    for (genvar s = 0; s < `RENAME_WIDTH; s++) begin : slotChk
        assert property (@(posedge clk) disable iff (!rstN) renameReq[s].valid |->
            renameResp[s].phySrc1 == expResp[s].phySrc1 &&
            renameResp[s].phySrc2 == expResp[s].phySrc2 &&
            renameResp[s].prevPhyDst == expResp[s].prevPhyDst)
            else begin
                failCount++;
                $display("CHECK FAILED at %0d ns: slot %0d lookup is %p, expected %p",
                         $time, s, $sampled(renameResp[s]), $sampled(expResp[s]));
            end
        assert property (@(posedge clk) disable iff (!rstN)
            renameReq[s].valid && renameReq[s].writeReg |->
            renameResp[s].phyDst == expResp[s].phyDst)
            else begin
                failCount++;
                $display("CHECK FAILED at %0d ns: slot %0d phyDst is %0d, expected %0d",
                         $time, s, $sampled(renameResp[s].phyDst), $sampled(expResp[s].phyDst));
            end
    end

    task automatic stepCycle();
        @(posedge clk);
        #10;
    endtask

    function automatic RenameReq makeReq(input logic wr);
        RenameReq r;
        r.valid    = 1'b1;
        r.writeReg = wr;
        r.logDst   = LRegNum'($random(seed));
        r.logSrc1  = LRegNum'($random(seed));
        r.logSrc2  = LRegNum'($random(seed));
        return r;
    endfunction

    // Holds the group until the DUT is ready, then presents it for one cycle
    task automatic renameGroup(input RenameReq r0, input RenameReq r1);
        while (!ready) begin
            stepCycle();
        end
        renameReq[0] = r0;
        renameReq[1] = r1;
        stepCycle();
        renameReq[0] = '0;
        renameReq[1] = '0;
    endtask

    task automatic commitOldest(input int n);
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (i < n && inflight.size() > 0) begin
                commitReq[i] = inflight.pop_front();
            end
        end
        stepCycle();
        commitReq[0] = '0;
        commitReq[1] = '0;
    endtask

    task automatic waitReady();
        while (!ready) begin
            stepCycle();
        end
    endtask

    task automatic finishTest(input string name);
        if (failCount == failsAtStart) begin
            passTests++;
            $display("%s: ok", name);
        end else begin
            failTests++;
            $display("%s: %0d checks failed", name, failCount - failsAtStart);
        end
        failsAtStart = failCount;
    endtask

    initial begin
        RenameReq r0;
        RenameReq r1;
        rstN         = 1'b0;
        flush        = 1'b0;
        renameReq[0] = '0;
        renameReq[1] = '0;
        commitReq[0] = '0;
        commitReq[1] = '0;
        repeat (16) @(posedge clk);
        #10;
        rstN = 1'b1;
        stepCycle();

        // Fresh allocations start at physical register 16
        renameGroup(makeReq(1'b1), makeReq(1'b1));
        renameGroup(makeReq(1'b1), makeReq(1'b0));
        renameGroup(makeReq(1'b1), makeReq(1'b1));
        finishTest("after reset");

        for (int i = 0; i < 5; i++) begin
            r0 = makeReq(1'b1);
            r1 = makeReq(1'b1);
            if (i % 2 == 0) begin
                r1.logSrc1 = r0.logDst;
                r1.logDst  = r0.logDst;
            end else begin
                r1.logSrc2 = r0.logDst;
            end
            renameGroup(r0, r1);
            commitOldest(2);
        end
        finishTest("source lookup");

        while (ready) begin
            renameGroup(makeReq(1'b1), makeReq(1'b1));
        end
        stepCycle();
        stepCycle();
        commitOldest(1);
        stepCycle();
        commitOldest(1);
        waitReady();
        finishTest("exhaustion");

        while (inflight.size() > 0) begin
            commitOldest(2);
        end
        for (int i = 0; i < 6; i++) begin
            renameGroup(makeReq(1'b1), makeReq(1'b1));
            commitOldest(2);
        end
        finishTest("commit recycling");

        // Squash four in-flight renames
        for (int i = 0; i < 4; i++) begin
            renameGroup(makeReq(1'b1), makeReq(1'b1));
        end
        commitOldest(2);
        commitOldest(2);
        flush = 1'b1;
        stepCycle();
        flush = 1'b0;
        waitReady();
        for (int i = 0; i < 4; i++) begin
            renameGroup(makeReq(1'b1), makeReq(1'b1));
            commitOldest(2);
        end
        finishTest("flush");

        stepCycle();
        $display("Tests: %0d passed, %0d failed", passTests, failTests);
        if (failCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hw
hw/RegTypesPkg.sv
hw/RenamePortPkg.sv
hw/FreeList.sv
hw/RenameMapTable.sv
hw/RetireMapTable.sv
hw/RenameLogic.sv
hw/RenameUnit.sv
tests/RenameUnitTb.sv

// File: Bender.yml
package:
  name: rename_unit

export_include_dirs:
  - hw

sources:
  - hw/RegTypesPkg.sv
  - hw/RenamePortPkg.sv
  - hw/FreeList.sv
  - hw/RenameMapTable.sv
  - hw/RetireMapTable.sv
  - hw/RenameLogic.sv
  - hw/RenameUnit.sv
  - target: test
    files:
      - tests/RenameUnitTb.sv
